/* vlog.f */
design/mutative_types.sv
design/mutative_plru.sv
design/mutative_tag_array.sv
design/mutative_data_array.sv
design/mutative_cache_ctrl.sv
design/mutative_cache.sv
verif/mutative_mem_model.sv
verif/mutative_cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mutative_cache_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk -v msg="$(PASS_MSG)" '{ print } $$0 == msg { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

/* verif/mutative_cache_tb.sv */
`timescale 1ns/100ps

module mutative_cache_tb;
    import mutative_types::*;

    typedef logic [ADDR_BITS-1:0] word_addr_t;

    localparam int    PERIOD       = 100;
    localparam int    RESET_CYCLES = 8;
    localparam int    ACCESS_LIMIT = 12; // lookup, fetch, 4 cycles latency, fill, margin
    localparam int    ACCESS_COUNT = 64; // upper bound over all tests
    localparam int    RUN_LIMIT    = RESET_CYCLES + ACCESS_COUNT * (ACCESS_LIMIT + 1) + 40;
    localparam data_t MEM_BASE     = 32'hc0de_0000;

    // 2-way pass in set 7, tags share tag[2:1]
    localparam tag_t        WAY2_TAGS [8]  = '{12'h032, 12'h042, 12'h032, 12'h053,
                                               12'h032, 12'h053, 12'h042, 12'h053};
    localparam logic [7:0]  WAY2_MISS      = 8'b0100_1011; // bit i set when access i misses
    // 4-way pass in set 11, tags share tag[2]
    localparam tag_t        WAY4_TAGS [11] = '{12'h064, 12'h075, 12'h086, 12'h097,
                                               12'h064, 12'h0a4, 12'h064, 12'h086,
                                               12'h097, 12'h0a4, 12'h075};
    localparam logic [10:0] WAY4_MISS      = 11'b100_0010_1111;

    logic       clk;
    logic       rst;
    logic       req;
    cpu_req_t   cpu;
    setup_t     setup;
    logic       flush;
    logic       busy;
    logic       done;
    data_t      rdata;
    logic       mem_req;
    mem_req_t   mem;
    logic       mem_ack;
    data_t      mem_rdata;

    string      test_name;
    logic       exp_we;
    word_addr_t exp_addr;
    data_t      exp_wdata;
    data_t      exp_data;
    logic       exp_mem;   // access must reach memory
    int         mem_seen;
    int         mem_base;
    int         errors;
    int         errors_at_start;
    int         tests_passed;
    int         tests_failed;
    data_t      written [word_addr_t];

    mutative_cache i_dut (.*);

    mutative_mem_model #(.BASE(MEM_BASE), .SEED(66)) i_mem (.*);

    always #(PERIOD/2) clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            mem_seen <= 0;
        end else if (mem_req) begin
            mem_seen <= mem_seen + 1;
        end
    end

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        done && !exp_we |-> rdata == exp_data)
    else begin
        $display("Error %s: rdata expected %h actual %h", test_name, exp_data, rdata);
        errors++;
    end

    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        $past(req && !exp_mem, 2) |-> done)
    else begin
        $display("Error %s: done 2 cycles after read hit req expected 1 actual %b",
                 test_name, done);
        errors++;
    end

    a_mem_count: assert property (@(posedge clk) disable iff (rst)
        done |-> mem_seen - mem_base == int'(exp_mem))
    else begin
        $display("Error %s: mem_req count expected %0d actual %0d",
                 test_name, int'(exp_mem), mem_seen - mem_base);
        errors++;
    end

    a_mem_fields: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> mem.we == exp_we && mem.addr == exp_addr &&
                    (!exp_we || mem.wdata == exp_wdata))
    else begin
        $display("Error %s: mem we addr data expected %b %h %h actual %b %h %h",
                 test_name, exp_we, exp_addr, exp_wdata, mem.we, mem.addr, mem.wdata);
        errors++;
    end

    // busy covers the access from lookup to the memory answer
    a_busy_active: assert property (@(posedge clk) disable iff (rst)
        ($past(req) || mem_req || mem_ack) |-> busy)
    else begin
        $display("Error %s: busy during access expected 1 actual %b", test_name, busy);
        errors++;
    end

    a_busy_done: assert property (@(posedge clk) disable iff (rst)
        done |-> !busy)
    else begin
        $display("Error %s: busy with done expected 0 actual %b", test_name, busy);
        errors++;
    end

    function automatic word_addr_t make_addr(input tag_t tag, input set_idx_t set);
        return {tag, set};
    endfunction

    // memory content as seen from the CPU side
    function automatic data_t expected_word(input word_addr_t addr);
        if (written.exists(addr)) begin
            return written[addr];
        end
        return MEM_BASE + data_t'(addr);
    endfunction

    task automatic access(input logic we, input word_addr_t addr, input data_t wdata,
                          input logic miss);
        int waited;
        @(posedge clk);
        #1;
        exp_we    = we;
        exp_addr  = addr;
        exp_wdata = wdata;
        exp_data  = we ? wdata : expected_word(addr);
        exp_mem   = we || miss;
        mem_base  = mem_seen;
        cpu       = '{we: we, addr: addr, wdata: wdata};
        req       = 1'b1;
        @(posedge clk);
        #1;
        req    = 1'b0;
        waited = 0;
        while (!done && waited < ACCESS_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!done) begin
            $display("no done within %0d cycles of req in test %s", ACCESS_LIMIT, test_name);
            errors++;
        end
        if (we) begin
            written[addr] = wdata;
        end
    endtask

    task automatic read_word(input word_addr_t addr, input logic miss);
        access(1'b0, addr, '0, miss);
    endtask

    task automatic write_word(input word_addr_t addr, input data_t wdata);
        access(1'b1, addr, wdata, 1'b1);
    endtask

    task automatic reconfigure(input setup_t level);
        @(posedge clk);
        #1;
        setup = level;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("test %-24s pass", test_name);
            tests_passed++;
        end else begin
            $display("test %-24s fail, %0d errors", test_name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    initial begin
        #(RUN_LIMIT * PERIOD);
        $display("watchdog expired after %0d cycles, DUT stopped responding", RUN_LIMIT);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        word_addr_t wt_addr;
        word_addr_t wm_addr;
        clk   = 1'b0;
        rst   = 1'b1;
        req   = 1'b0;
        cpu   = '0;
        setup = SETUP_8WAY;
        flush = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;

        begin_test("read miss then hit");
        read_word(make_addr(12'h025, 4'd3), 1'b1);
        read_word(make_addr(12'h025, 4'd3), 1'b0);
        end_test();

        begin_test("direct-mapped conflict");
        reconfigure(SETUP_DM);
        for (int i = 0; i < 4; i++) begin
            read_word(make_addr((i % 2 == 0) ? 12'h010 : 12'h020, 4'd5), 1'b1);
        end
        read_word(make_addr(12'h011, 4'd5), 1'b1); // tag[2:0] = 1, own way
        read_word(make_addr(12'h020, 4'd5), 1'b0);
        read_word(make_addr(12'h011, 4'd5), 1'b0);
        end_test();

        begin_test("8-way replacement");
        reconfigure(SETUP_8WAY);
        for (int i = 0; i < 16; i++) begin
            read_word(make_addr(tag_t'(12'h100 + i % 8), 4'd9), i < 8);
        end
        read_word(make_addr(12'h108, 4'd9), 1'b1); // ninth tag, first fill goes
        for (int i = 1; i < 8; i++) begin
            read_word(make_addr(tag_t'(12'h100 + i), 4'd9), 1'b0);
        end
        read_word(make_addr(12'h100, 4'd9), 1'b1);
        end_test();

        begin_test("write-through");
        wt_addr = make_addr(12'h033, 4'd12);
        wm_addr = make_addr(12'h044, 4'd12);
        read_word(wt_addr, 1'b1);
        write_word(wt_addr, 32'h1234_5678);
        read_word(wt_addr, 1'b0);
        write_word(wm_addr, 32'h9abc_def0); // no allocation on a write miss
        read_word(wm_addr, 1'b1);
        end_test();

        begin_test("2-way reconfiguration");
        reconfigure(SETUP_2WAY);
        read_word(make_addr(12'h102, 4'd9), 1'b1); // way 2 still holds it, inside its group
        read_word(wt_addr, 1'b1);
        for (int i = 0; i < 8; i++) begin
            read_word(make_addr(WAY2_TAGS[i], 4'd7), WAY2_MISS[i]);
        end
        end_test();

        begin_test("4-way reconfiguration");
        reconfigure(SETUP_4WAY);
        read_word(make_addr(12'h042, 4'd7), 1'b1); // left in way 2 by the 2-way pass
        read_word(make_addr(12'h042, 4'd7), 1'b0);
        for (int i = 0; i < 11; i++) begin
            read_word(make_addr(WAY4_TAGS[i], 4'd11), WAY4_MISS[i]);
        end
        end_test();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verif/mutative_mem_model.sv */
`timescale 1ns/100ps

module mutative_mem_model #(
    parameter mutative_types::data_t BASE = '0,
    parameter int unsigned           SEED = 1
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mem_req,
    input  mutative_types::mem_req_t mem,
    output logic                     mem_ack,
    output mutative_types::data_t    mem_rdata
);
    import mutative_types::*;

    data_t words [2**ADDR_BITS];

    initial begin
        mem_req_t    pending;
        int unsigned latency;
        for (int a = 0; a < 2**ADDR_BITS; a++) begin
            words[a] = BASE + data_t'(a); // distinct word per address
        end
        mem_ack   = 1'b0;
        mem_rdata = '0;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            if (!rst && mem_req) begin
                pending = mem;
                latency = $urandom_range(4, 1); // ack 1 to 4 cycles later
                repeat (latency - 1) begin
                    @(posedge clk);
                end
                #1;
                mem_ack = 1'b1;
                if (pending.we) begin
                    words[pending.addr] = pending.wdata;
                end else begin
                    mem_rdata = words[pending.addr];
                end
                @(posedge clk);
                #1;
                mem_ack = 1'b0;
            end
        end
    end

endmodule

/* design/mutative_cache.sv */
`timescale 1ns/100ps

module mutative_cache (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  mutative_types::cpu_req_t cpu,
    input  mutative_types::setup_t   setup,
    input  logic                     flush,
    output logic                     busy,
    output logic                     done,
    output mutative_types::data_t    rdata,
    output logic                     mem_req,
    output mutative_types::mem_req_t mem,
    input  logic                     mem_ack,
    input  mutative_types::data_t    mem_rdata
);
    import mutative_types::*;

    cache_address_t cache_address;
    logic           hit;
    way_idx_t       hit_way;
    way_mask_t      hit_mask;
    way_idx_t       evict_way;
    way_mask_t      evict_we;
    logic           touch;
    way_idx_t       touch_way;
    way_mask_t      array_we;
    data_t          array_wdata;
    data_t          array_rdata;
    way_idx_t       rd_way;
    logic           flush_idle;

    assign flush_idle = flush & ~busy; // flush only between requests

    mutative_cache_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .cpu          (cpu),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_mask     (hit_mask),
        .evict_way    (evict_way),
        .evict_we     (evict_we),
        .array_rdata  (array_rdata),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .cache_address(cache_address),
        .touch        (touch),
        .touch_way    (touch_way),
        .array_we     (array_we),
        .array_wdata  (array_wdata),
        .rd_way       (rd_way),
        .mem_req      (mem_req),
        .mem          (mem),
        .busy         (busy),
        .done         (done),
        .rdata        (rdata)
    );

    mutative_tag_array i_tag_array (
        .clk          (clk),
        .rst          (rst),
        .cache_address(cache_address),
        .setup        (setup),
        .we           (array_we),
        .flush        (flush_idle),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_mask     (hit_mask)
    );

    mutative_data_array i_data_array (
        .clk          (clk),
        .cache_address(cache_address),
        .we           (array_we),
        .wdata        (array_wdata),
        .rd_way       (rd_way),
        .rdata        (array_rdata)
    );

    mutative_plru i_plru (
        .clk          (clk),
        .rst          (rst),
        .hit_way      (touch_way),
        .hit          (touch),
        .cache_address(cache_address),
        .setup        (setup),
        .evict_way    (evict_way),
        .evict_we     (evict_we)
    );

endmodule

/* design/mutative_cache_ctrl.sv */
`timescale 1ns/100ps

module mutative_cache_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req,
    input  mutative_types::cpu_req_t       cpu,
    input  logic                           hit,
    input  mutative_types::way_idx_t       hit_way,
    input  mutative_types::way_mask_t      hit_mask,
    input  mutative_types::way_idx_t       evict_way,
    input  mutative_types::way_mask_t      evict_we,
    input  mutative_types::data_t          array_rdata,
    input  logic                           mem_ack,
    input  mutative_types::data_t          mem_rdata,
    output mutative_types::cache_address_t cache_address,
    output logic                           touch,
    output mutative_types::way_idx_t       touch_way,
    output mutative_types::way_mask_t      array_we,
    output mutative_types::data_t          array_wdata,
    output mutative_types::way_idx_t       rd_way,
    output logic                           mem_req,
    output mutative_types::mem_req_t       mem,
    output logic                           busy,
    output logic                           done,
    output mutative_types::data_t          rdata
);
    import mutative_types::*;

    ctrl_state_t state;
    cpu_req_t    req_q;

    assign cache_address = req_q.addr;
    assign busy          = (state != ST_IDLE);
    assign rd_way        = hit_way;
    assign mem           = '{we: req_q.we, addr: req_q.addr, wdata: req_q.wdata};

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            done    <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            done    <= 1'b0;
            mem_req <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (req_q.we) begin
                        mem_req <= 1'b1; // write-through, hit or miss
                        state   <= ST_WRITE;
                    end else if (hit) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end else begin
                        mem_req <= 1'b1;
                        state   <= ST_FETCH;
                    end
                end
                ST_FETCH, ST_WAIT: begin
                    state <= mem_ack ? ST_FILL : ST_WAIT;
                end
                ST_FILL: begin
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end
                ST_WRITE: begin
                    if (mem_ack) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            req_q <= cpu;
        end
        if (state == ST_LOOKUP && hit) begin
            rdata <= array_rdata;
        end else if ((state == ST_FETCH || state == ST_WAIT) && mem_ack) begin
            rdata <= mem_rdata; // also the fill word
        end
    end

    always_comb begin
        touch       = 1'b0;
        touch_way   = hit_way;
        array_we    = '0;
        array_wdata = req_q.wdata;
        case (state)
            ST_LOOKUP: begin
                if (hit) begin
                    touch = 1'b1;
                    if (req_q.we) begin
                        array_we = hit_mask; // write hit updates the word
                    end
                end
            end
            ST_FILL: begin
                touch       = 1'b1;
                touch_way   = evict_way;
                array_we    = evict_we;
                array_wdata = rdata;
            end
            default: begin
            end
        endcase
    end

    a_req_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        req |-> !busy
    ) else $error("req while busy is ignored");

    // a new request never meets the ack of an earlier one
    a_mem_req_origin: assert property (
        @(posedge clk) disable iff (rst)
        mem_req |-> $past(state) == ST_LOOKUP && !mem_ack
    ) else $error("mem_req outside lookup exit or during mem_ack");

endmodule

/* design/mutative_data_array.sv */
`timescale 1ns/100ps

module mutative_data_array (
    input  logic                           clk,
    input  mutative_types::cache_address_t cache_address,
    input  mutative_types::way_mask_t      we,
    input  mutative_types::data_t          wdata,
    input  mutative_types::way_idx_t       rd_way,
    output mutative_types::data_t          rdata
);
    import mutative_types::*;

    data_t words [SET_SIZE][WAYS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (we[w]) begin
                words[cache_address.set_index][w] <= wdata;
            end
        end
    end

    assign rdata = words[cache_address.set_index][rd_way]; // async read

endmodule

/* design/mutative_tag_array.sv */
`timescale 1ns/100ps

module mutative_tag_array (
    input  logic                           clk,
    input  logic                           rst,
    input  mutative_types::cache_address_t cache_address,
    input  mutative_types::setup_t         setup,
    input  mutative_types::way_mask_t      we,
    input  logic                           flush,
    output logic                           hit,
    output mutative_types::way_idx_t       hit_way,
    output mutative_types::way_mask_t      hit_mask
);
    import mutative_types::*;

    tag_t      tags  [SET_SIZE][WAYS];
    way_mask_t valid [SET_SIZE];
    way_mask_t group;
    way_mask_t match;

    assign group = group_mask(setup, cache_address.tag);

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            match[w] = (tags[cache_address.set_index][w] == cache_address.tag);
        end
    end

    // only ways of the selected group take part in the compare
    assign hit_mask = group & valid[cache_address.set_index] & match;
    assign hit      = |hit_mask;
    assign hit_way  = onehot_to_idx(hit_mask);

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (we[w]) begin
                tags[cache_address.set_index][w] <= cache_address.tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int s = 0; s < SET_SIZE; s++) begin
                valid[s] <= '0; // all lines at once
            end
        end else begin
            valid[cache_address.set_index] <= valid[cache_address.set_index] | we;
        end
    end

    // duplicate tags in a group would mean a fill of an already cached line
    a_hit_unique: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(hit_mask)
    ) else $error("multiple ways hit: %b", hit_mask);

endmodule

/* design/mutative_plru.sv */
`timescale 1ns/100ps

module mutative_plru (
    input  logic                           clk,
    input  logic                           rst,
    input  mutative_types::way_idx_t       hit_way,
    input  logic                           hit,
    input  mutative_types::cache_address_t cache_address,
    input  mutative_types::setup_t         setup,
    output mutative_types::way_idx_t       evict_way,
    output mutative_types::way_mask_t      evict_we
);
    import mutative_types::*;

    way_mask_t             mru_bits [SET_SIZE];
    way_mask_t             group;
    way_mask_t             set_bits;
    way_mask_t             free;
    way_mask_t             candidates;
    logic [WAY_IDX_BITS:0] free_count;
    logic                  last_free;

    assign group    = group_mask(setup, cache_address.tag);
    assign set_bits = mru_bits[cache_address.set_index];
    assign free     = group & ~set_bits; // not recently used ways of the group

    always_comb begin
        free_count = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (free[i]) begin
                free_count++;
            end
        end
    end

    assign last_free = (free_count == (WAY_IDX_BITS+1)'(1));

    // A group can be fully marked after a setup change, or always in
    // direct-mapped mode. The victim is then simply the lowest way of the group.
    assign candidates = (free != '0) ? free : group;
    assign evict_we   = candidates & (~candidates + 1'b1); // lowest set bit
    assign evict_way  = onehot_to_idx(evict_we);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SET_SIZE; s++) begin
                mru_bits[s] <= '0;
            end
        end else if (hit && !set_bits[hit_way]) begin
            if (last_free) begin
                // group would saturate, keep only the touched way
                mru_bits[cache_address.set_index] <= (set_bits & ~group) |
                                                     (way_mask_t'(1) << hit_way);
            end else begin
                mru_bits[cache_address.set_index][hit_way] <= 1'b1;
            end
        end
    end

    // a touched way must belong to the group of the address
    a_evict_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot(evict_we) && (!hit || group[hit_way])
    ) else $error("evict_we %b not one-hot or touch of way %0d outside group %b",
                  evict_we, hit_way, group);

endmodule

/* design/mutative_types.sv */
package mutative_types;

    localparam int ADDR_BITS    = 16;
    localparam int WAYS         = 8;
    localparam int WAY_IDX_BITS = 3;
    localparam int SET_SIZE     = 16;
    localparam int SET_BITS     = 4;
    localparam int TAG_BITS     = ADDR_BITS - SET_BITS;
    localparam int DATA_BITS    = 32;

    typedef logic [WAY_IDX_BITS-1:0] way_idx_t;
    typedef logic [WAYS-1:0]         way_mask_t;
    typedef logic [TAG_BITS-1:0]     tag_t;
    typedef logic [SET_BITS-1:0]     set_idx_t;
    typedef logic [DATA_BITS-1:0]    data_t;
    typedef logic [1:0]              setup_t;

    localparam setup_t SETUP_DM    = 2'd0;
    localparam setup_t SETUP_2WAY  = 2'd1;
    localparam setup_t SETUP_4WAY  = 2'd2;
    localparam setup_t SETUP_8WAY  = 2'd3;

    typedef struct packed {
        tag_t     tag;
        set_idx_t set_index;
    } cache_address_t;

    typedef struct packed {
        logic           we;
        cache_address_t addr;
        data_t          wdata;
    } cpu_req_t;

    typedef struct packed {
        logic           we;
        cache_address_t addr;
        data_t          wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_FETCH,
        ST_WAIT,
        ST_FILL,
        ST_WRITE
    } ctrl_state_t;

    // ways that an address may live in under the given organization
    function automatic way_mask_t group_mask(setup_t setup, tag_t tag);
        way_mask_t mask;
        case (setup)
            SETUP_DM:   mask = way_mask_t'(1) << tag[2:0];
            SETUP_2WAY: mask = way_mask_t'(2'b11) << {tag[2:1], 1'b0};
            SETUP_4WAY: mask = way_mask_t'(4'hf) << {tag[2], 2'b00};
            default:    mask = '1;
        endcase
        return mask;
    endfunction

    function automatic way_idx_t onehot_to_idx(way_mask_t mask);
        way_idx_t idx;
        idx = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (mask[i]) begin
                idx = idx | way_idx_t'(i);
            end
        end
        return idx;
    endfunction

endpackage
